/* Makefile */
# Verilator build and run for the fetch front end

VERILATOR ?= verilator
TOP       ?= tb_fetch_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= TEST RESULT: PASS

SOURCES  := $(shell grep -v '^+' $(FILELIST))
HEADERS  := $(wildcard include/*.svh)
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when the file list, a source or a header changes
$(OBJ_DIR)/V%: $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $* --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the simulator output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* include/fetch_cfg.svh */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// pc register starts one word early, so the first sequential fetch is 0x1C000000
`define FETCH_RESET_PC 32'h1BFF_FFFC

// instruction tlb geometry
`define ITLB_ENTRIES   4
`define ITLB_IDX_W     2

`endif

/* project.f */
+incdir+include
src/fetch_pkg.sv
src/dmw_translator.sv
src/itlb_lookup.sv
src/fetch_stage.sv
src/fetch_top.sv
testbench/inst_mem_model.sv
testbench/tb_fetch_top.sv

/* src/dmw_translator.sv */
module dmw_translator (
    input  fetch_pkg::csr_view_t csr,
    input  logic [31:0]          va,
    output logic                 use_tlb,
    output logic [31:0]          pa
);
    logic [1:0] plv;
    logic       da;
    logic       win0_hit;
    logic       win1_hit;

    assign plv = csr.crmd[1:0];
    assign da  = csr.crmd[3];

    // each window holds plv enables in 3:0, pseg in 27:25 and vseg in 31:29
    assign win0_hit = (csr.dmw0[31:29] == va[31:29]) && csr.dmw0[plv];
    assign win1_hit = (csr.dmw1[31:29] == va[31:29]) && csr.dmw1[plv];

    always_comb
    begin
        use_tlb = 1'b0;
        pa      = va;           // direct address mode
        if (!da)
        begin
            if (win0_hit)
                pa = {csr.dmw0[27:25], va[28:0]};
            else if (win1_hit)
                pa = {csr.dmw1[27:25], va[28:0]};
            else
                use_tlb = 1'b1; // no window hit so the tlb translates
        end
    end

    // software must never leave both translation modes enabled
    always_comb
    begin
        a_da_pg_exclusive: assert (!(csr.crmd[3] && csr.crmd[4]))
            else $error("dmw_translator: crmd has da and pg both set");
    end

endmodule

/* src/fetch_pkg.sv */
`include "fetch_cfg.svh"

package fetch_pkg;

    typedef logic [`ITLB_IDX_W-1:0] tlb_idx_t;

    // branch result from execute
    typedef struct packed {
        logic        stall;     // branch not resolved yet
        logic        taken;
        logic [31:0] target;
    } br_bus_t;

    typedef struct packed {
        logic ex;
        logic ertn;
        logic refetch;
    } wb_redirect_t;

    typedef struct packed {
        logic [31:0] eentry;
        logic [31:0] era;
        logic [31:0] refetch_pc;
        logic [31:0] dmw0;
        logic [31:0] dmw1;
        logic [31:0] crmd;      // plv 1:0, da 3, pg 4
    } csr_view_t;

    // 4 KB pages only, even/odd pair per entry
    typedef struct packed {
        logic [18:0] vppn;
        logic [9:0]  asid;
        logic        g;
        logic [19:0] ppn0;
        logic [19:0] ppn1;
        logic        v0;
        logic        v1;
        logic [1:0]  plv0;
        logic [1:0]  plv1;
    } tlb_entry_t;

    typedef struct packed {
        logic        found;
        logic        v;
        logic [1:0]  plv;
        logic [19:0] ppn;
    } tlb_result_t;

    typedef struct packed {
        logic        tlbr;
        logic        pif;
        logic        ppi;
        logic        refetch_needed;
        logic        adef;
        logic [31:0] inst;
        logic [31:0] pc;
    } fs_to_ds_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } inst_req_t;

endpackage

/* src/fetch_stage.sv */
`include "fetch_cfg.svh"

module fetch_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    ds_allowin,
    input  fetch_pkg::br_bus_t      br_bus,
    input  fetch_pkg::wb_redirect_t wb_redirect,
    input  fetch_pkg::csr_view_t    csr,
    input  logic                    csr_critical_change,
    output logic [31:0]             next_pc,
    input  logic                    use_tlb,
    input  logic [31:0]             dmw_pa,
    input  fetch_pkg::tlb_result_t  tlb_res,
    output fetch_pkg::inst_req_t    inst_req,
    input  logic                    inst_addr_ok,
    input  logic                    inst_data_ok,
    input  logic [31:0]             inst_rdata,
    output logic                    fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_t    fs_to_ds
);
    // one-hot state bit positions
    localparam int S_ACC     = 0;   // wait for addr_ok
    localparam int S_DATA    = 1;   // wait for data or for decode to take it
    localparam int S_DATA_BR = 2;   // wait for data of a redirect target
    localparam int S_ACC_RD  = 3;   // redirect target held, wait for addr_ok
    localparam int S_DROP    = 4;   // stale fetch in flight

    logic [4:0]  state;
    logic [4:0]  state_nxt;
    logic        fs_valid;
    logic [31:0] fs_pc;
    logic        fs_adef;
    logic        fs_tlbr;
    logic        fs_pif;
    logic        fs_ppi;
    logic        fs_refetch;
    logic [31:0] pend_pc;
    logic        buf_valid;
    logic [31:0] buf_inst;
    logic        br_taken;
    logic        wb_any;
    logic        redirect;
    logic        pending;
    logic        handshake;
    logic        fs_allowin;
    logic        fs_ready_go;
    logic        deliver;

    assign br_taken = br_bus.taken && !br_bus.stall;
    assign wb_any   = wb_redirect.ex || wb_redirect.ertn || wb_redirect.refetch;
    assign redirect = wb_any || br_taken;
    assign pending  = state[S_ACC_RD] || state[S_DROP];

    // writeback outranks everything and a held target outranks a new branch
    always_comb
    begin
        if (wb_redirect.refetch)
            next_pc = csr.refetch_pc;
        else if (wb_redirect.ex)
            next_pc = csr.eentry;
        else if (wb_redirect.ertn)
            next_pc = csr.era;
        else if (pending)
            next_pc = pend_pc;
        else if (br_taken)
            next_pc = br_bus.target;
        else
            next_pc = fs_pc + 32'd4;
    end

    always_ff @(posedge clk)
    begin
        pend_pc <= next_pc;     // holds itself while pending
    end

    assign fs_ready_go    = buf_valid || inst_data_ok;
    assign fs_to_ds_valid = fs_valid && fs_ready_go && !redirect;
    assign deliver        = fs_to_ds_valid && ds_allowin;
    assign fs_allowin     = !fs_valid || deliver || redirect;

    assign inst_req.valid = fs_allowin && (state[S_ACC] || state[S_ACC_RD]) && !br_bus.stall;
    assign inst_req.addr  = use_tlb ? {tlb_res.ppn, next_pc[11:0]} : dmw_pa;
    assign handshake      = inst_req.valid && inst_addr_ok;

    always_ff @(posedge clk)
    begin
        if (reset)
            fs_valid <= 1'b0;
        else if (handshake)
            fs_valid <= 1'b1;
        else if (redirect || deliver)
            fs_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            fs_pc <= `FETCH_RESET_PC;
        else if (handshake)
            fs_pc <= next_pc;
    end

    // flags ride along with the accepted pc
    always_ff @(posedge clk)
    begin
        if (handshake)
        begin
            fs_adef    <= next_pc[1:0] != 2'b00;
            fs_tlbr    <= use_tlb && !tlb_res.found;
            fs_pif     <= use_tlb && tlb_res.found && !tlb_res.v;
            fs_ppi     <= use_tlb && tlb_res.found && tlb_res.v && (csr.crmd[1:0] > tlb_res.plv);
            fs_refetch <= csr_critical_change;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            buf_valid <= 1'b0;
        else if (deliver || redirect)
            buf_valid <= 1'b0;
        else if (inst_data_ok && fs_valid && !ds_allowin)
            buf_valid <= 1'b1;  // park it while decode stalls
    end

    always_ff @(posedge clk)
    begin
        if (inst_data_ok)
            buf_inst <= inst_rdata;
    end

    always_comb
    begin
        state_nxt = '0;
        unique case (1'b1)
            state[S_ACC]:
                if (handshake)
                    state_nxt[redirect ? S_DATA_BR : S_DATA] = 1'b1;
                else
                    state_nxt[redirect ? S_ACC_RD : S_ACC] = 1'b1;
            state[S_DATA]:
                if (redirect)
                    state_nxt[(buf_valid || inst_data_ok) ? S_ACC_RD : S_DROP] = 1'b1;
                else
                    state_nxt[deliver ? S_ACC : S_DATA] = 1'b1;
            state[S_DATA_BR]:
                if (redirect)
                    state_nxt[inst_data_ok ? S_ACC_RD : S_DROP] = 1'b1;
                else
                    state_nxt[inst_data_ok ? S_ACC : S_DATA_BR] = 1'b1;
            state[S_ACC_RD]:
                state_nxt[handshake ? S_DATA_BR : S_ACC_RD] = 1'b1;
            default:
                state_nxt[inst_data_ok ? S_ACC_RD : S_DROP] = 1'b1;  // swallow stale data
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= 5'b00001;
        else
            state <= state_nxt;
    end

    assign fs_to_ds.tlbr           = fs_tlbr;
    assign fs_to_ds.pif            = fs_pif;
    assign fs_to_ds.ppi            = fs_ppi;
    assign fs_to_ds.refetch_needed = fs_refetch;
    assign fs_to_ds.adef           = fs_adef;
    assign fs_to_ds.inst           = buf_valid ? buf_inst : inst_rdata;
    assign fs_to_ds.pc             = fs_pc;

    // the drop state is left only once the stale data has come back
    a_no_req_in_drop: assert property (@(posedge clk) disable iff (reset)
        state[S_DROP] && !inst_data_ok |=> !inst_req.valid)
        else $error("fetch_stage: request issued while a stale fetch is in flight");

    a_parked_stable: assert property (@(posedge clk) disable iff (reset)
        fs_to_ds_valid && !ds_allowin |=> redirect || (fs_to_ds_valid && $stable(fs_to_ds)))
        else $error("fetch_stage: parked instruction changed before decode took it");

endmodule

/* src/fetch_top.sv */
`include "fetch_cfg.svh"

module fetch_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    ds_allowin,
    input  fetch_pkg::br_bus_t      br_bus,
    input  fetch_pkg::wb_redirect_t wb_redirect,
    input  fetch_pkg::csr_view_t    csr,
    input  logic                    csr_critical_change,
    input  logic [9:0]              csr_asid,
    input  logic                    tlb_we,
    input  logic [`ITLB_IDX_W-1:0]  tlb_windex,
    input  fetch_pkg::tlb_entry_t   tlb_wentry,
    output fetch_pkg::inst_req_t    inst_req,
    input  logic                    inst_addr_ok,
    input  logic                    inst_data_ok,
    input  logic [31:0]             inst_rdata,
    output logic                    fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_t    fs_to_ds
);
    import fetch_pkg::*;

    logic [31:0] next_pc;   // virtual
    logic        use_tlb;
    logic [31:0] dmw_pa;
    tlb_result_t tlb_res;

    fetch_stage u_fetch_stage (
        .clk                 (clk),
        .reset               (reset),
        .ds_allowin          (ds_allowin),
        .br_bus              (br_bus),
        .wb_redirect         (wb_redirect),
        .csr                 (csr),
        .csr_critical_change (csr_critical_change),
        .next_pc             (next_pc),
        .use_tlb             (use_tlb),
        .dmw_pa              (dmw_pa),
        .tlb_res             (tlb_res),
        .inst_req            (inst_req),
        .inst_addr_ok        (inst_addr_ok),
        .inst_data_ok        (inst_data_ok),
        .inst_rdata          (inst_rdata),
        .fs_to_ds_valid      (fs_to_ds_valid),
        .fs_to_ds            (fs_to_ds)
    );

    dmw_translator u_dmw_translator (
        .csr     (csr),
        .va      (next_pc),
        .use_tlb (use_tlb),
        .pa      (dmw_pa)
    );

    itlb_lookup u_itlb_lookup (
        .clk      (clk),
        .reset    (reset),
        .asid     (csr_asid),
        .vppn     (next_pc[31:13]),
        .va_bit12 (next_pc[12]),
        .we       (tlb_we),
        .windex   (tlb_windex),
        .wentry   (tlb_wentry),
        .result   (tlb_res)
    );

endmodule

/* src/itlb_lookup.sv */
`include "fetch_cfg.svh"

module itlb_lookup (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [9:0]             asid,
    input  logic [18:0]            vppn,
    input  logic                   va_bit12,
    input  logic                   we,
    input  logic [`ITLB_IDX_W-1:0] windex,
    input  fetch_pkg::tlb_entry_t  wentry,
    output fetch_pkg::tlb_result_t result
);
    import fetch_pkg::*;

    tlb_entry_t               entries [`ITLB_ENTRIES];
    logic [`ITLB_ENTRIES-1:0] entry_valid;
    logic [`ITLB_ENTRIES-1:0] match;
    tlb_idx_t                 hit_idx;
    tlb_entry_t               hit;

    always_ff @(posedge clk)
    begin
        if (reset)
            entry_valid <= '0;
        else if (we)
            entry_valid[windex] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (we)
            entries[windex] <= wentry;
    end

    // global entries match under any asid
    always_comb
    begin
        hit_idx = '0;
        for (int i = 0; i < `ITLB_ENTRIES; i++)
        begin
            match[i] = entry_valid[i] && (entries[i].vppn == vppn)
                       && (entries[i].g || (entries[i].asid == asid));
            if (match[i])
                hit_idx = tlb_idx_t'(i);
        end
    end

    assign hit = entries[hit_idx];

    // va bit 12 picks the odd or even half of the pair
    assign result.found = |match;
    assign result.v     = va_bit12 ? hit.v1   : hit.v0;
    assign result.plv   = va_bit12 ? hit.plv1 : hit.plv0;
    assign result.ppn   = va_bit12 ? hit.ppn1 : hit.ppn0;

    a_single_match: assert property (@(posedge clk) disable iff (reset) $onehot0(match))
        else $error("itlb_lookup: several entries match vppn %h", vppn);

endmodule

/* testbench/inst_mem_model.sv */
module inst_mem_model (
    input  logic                 clk,
    input  logic                 reset,
    input  fetch_pkg::inst_req_t inst_req,
    output logic                 inst_addr_ok,
    output logic                 inst_data_ok,
    output logic [31:0]          inst_rdata
);
    localparam logic [31:0] DATA_KEY = 32'hA5A5_0000;

    integer      seed;
    logic        busy;          // one request outstanding
    logic [31:0] held_addr;
    int          addr_wait;
    int          data_wait;
    logic        s_reset;
    logic        s_take;
    logic [31:0] s_addr;
    logic [31:0] rnd;

    initial
    begin
        seed         = 32'h0051_dcfd;
        busy         = 1'b0;
        held_addr    = '0;
        addr_wait    = 0;
        data_wait    = 0;
        inst_addr_ok = 1'b0;
        inst_data_ok = 1'b0;
        inst_rdata   = '0;
    end

    // sample at the edge, drive the next cycle's response shortly after
    always @(posedge clk)
    begin
        s_reset = reset;
        s_take  = inst_req.valid && inst_addr_ok;
        s_addr  = inst_req.addr;
        #1;
        inst_data_ok = 1'b0;
        if (s_reset)
        begin
            busy         = 1'b0;
            addr_wait    = 0;
            inst_addr_ok = 1'b0;
        end
        else
        begin
            if (s_take)
            begin
                busy         = 1'b1;
                held_addr    = s_addr;
                inst_addr_ok = 1'b0;
                rnd          = $random(seed);
                data_wait    = int'(rnd % 3);   // data 1 to 3 cycles later
            end
            if (busy)
            begin
                if (data_wait == 0)
                begin
                    inst_data_ok = 1'b1;
                    inst_rdata   = held_addr ^ DATA_KEY;
                    busy         = 1'b0;
                    rnd          = $random(seed);
                    addr_wait    = int'(rnd % 3);
                end
                else
                    data_wait = data_wait - 1;
            end
            else if (addr_wait == 0)
                inst_addr_ok = 1'b1;            // held until a request takes it
            else
                addr_wait = addr_wait - 1;
        end
    end

endmodule

/* testbench/tb_fetch_top.sv */
`include "fetch_cfg.svh"

module tb_fetch_top;
    import fetch_pkg::*;

    localparam logic [31:0] DATA_KEY   = 32'hA5A5_0000;
    // roughly 60 deliveries at up to a dozen cycles each plus two stall windows
    localparam int          MAX_CYCLES = 4000;
    localparam logic [4:0]  NO_FLAGS   = 5'b00000;  // {tlbr, pif, ppi, refetch, adef}
    localparam logic [4:0]  F_TLBR     = 5'b10000;
    localparam logic [4:0]  F_PIF      = 5'b01000;
    localparam logic [4:0]  F_PPI      = 5'b00100;
    localparam logic [4:0]  F_REFETCH  = 5'b00010;
    localparam logic [4:0]  F_ADEF     = 5'b00001;

    logic                   clk;
    logic                   reset;
    logic                   ds_allowin;
    br_bus_t                br_bus;
    wb_redirect_t           wb_redirect;
    csr_view_t              csr;
    logic                   csr_critical_change;
    logic [9:0]             csr_asid;
    logic                   tlb_we;
    logic [`ITLB_IDX_W-1:0] tlb_windex;
    tlb_entry_t             tlb_wentry;
    inst_req_t              inst_req;
    logic                   inst_addr_ok;
    logic                   inst_data_ok;
    logic [31:0]            inst_rdata;
    logic                   fs_to_ds_valid;
    fs_to_ds_t              fs_to_ds;

    fs_to_ds_t got_q[$];            // every payload decode accepted
    integer    seed;
    int        errors;
    int        checks;
    int        mon_errors = 0;
    int        cycles = 0;
    logic      no_req_expected;
    logic      was_held = 1'b0;
    fs_to_ds_t held_item;
    logic      redirect_now;

    fetch_top u_fetch_top (
        .clk                 (clk),
        .reset               (reset),
        .ds_allowin          (ds_allowin),
        .br_bus              (br_bus),
        .wb_redirect         (wb_redirect),
        .csr                 (csr),
        .csr_critical_change (csr_critical_change),
        .csr_asid            (csr_asid),
        .tlb_we              (tlb_we),
        .tlb_windex          (tlb_windex),
        .tlb_wentry          (tlb_wentry),
        .inst_req            (inst_req),
        .inst_addr_ok        (inst_addr_ok),
        .inst_data_ok        (inst_data_ok),
        .inst_rdata          (inst_rdata),
        .fs_to_ds_valid      (fs_to_ds_valid),
        .fs_to_ds            (fs_to_ds)
    );

    inst_mem_model u_inst_mem (
        .clk          (clk),
        .reset        (reset),
        .inst_req     (inst_req),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // a payload parked at decode must not change until taken
    always @(posedge clk)
    begin
        redirect_now = (wb_redirect != 3'b000) || (br_bus.taken && !br_bus.stall);
        if (reset)
            was_held = 1'b0;
        else
        begin
            if (was_held && !redirect_now && !(fs_to_ds_valid && fs_to_ds == held_item))
            begin
                mon_errors++;
                $display("[FAIL] %0t: parked payload for pc %h changed or vanished",
                         $time, held_item.pc);
            end
            if (no_req_expected && inst_req.valid)
            begin
                mon_errors++;
                $display("[FAIL] %0t: fetch request issued during branch stall", $time);
            end
            if (fs_to_ds_valid && ds_allowin)
                got_q.push_back(fs_to_ds);
            was_held  = fs_to_ds_valid && !ds_allowin;
            held_item = fs_to_ds;
        end
    end

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_items(input int count);
        while (got_q.size() < count)
            next_cycle();
    endtask

    task automatic report_mismatch(input string msg);
        errors++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    // pc and physical address both step by 4 over n items
    task automatic check_run(input int first, input int n, input logic [31:0] pc0,
                             input logic [31:0] pa0, input logic [4:0] flags,
                             input bit check_inst);
        fs_to_ds_t   item;
        logic [4:0]  got_flags;
        logic [31:0] exp_pc;
        logic [31:0] exp_pa;
        for (int k = 0; k < n; k++)
        begin
            item      = got_q[first + k];
            got_flags = {item.tlbr, item.pif, item.ppi, item.refetch_needed, item.adef};
            exp_pc    = pc0 + 4 * k;
            exp_pa    = pa0 + 4 * k;
            checks++;
            if (item.pc !== exp_pc)
                report_mismatch($sformatf("item %0d pc %h, expected %h",
                                          first + k, item.pc, exp_pc));
            if (got_flags !== flags)
                report_mismatch($sformatf("pc %h flags %b, expected %b",
                                          item.pc, got_flags, flags));
            if (check_inst && item.inst !== (exp_pa ^ DATA_KEY))
                report_mismatch($sformatf("pc %h inst %h, expected %h",
                                          item.pc, item.inst, exp_pa ^ DATA_KEY));
        end
    endtask

    task automatic branch_to(input logic [31:0] dest, output int first);
        br_bus = '{stall: 1'b0, taken: 1'b1, target: dest};
        first  = got_q.size();
        next_cycle();
        br_bus = '0;
    endtask

    task automatic writeback_to(input logic ex, input logic ertn, input logic refetch,
                                output int first);
        wb_redirect.ex      = ex;
        wb_redirect.ertn    = ertn;
        wb_redirect.refetch = refetch;
        first               = got_q.size();
        next_cycle();
        wb_redirect = '0;
    endtask

    task automatic refetch_to(input logic [31:0] dest, output int first);
        csr.refetch_pc = dest;
        writeback_to(1'b0, 1'b0, 1'b1, first);
    endtask

    task automatic write_tlb(input logic [`ITLB_IDX_W-1:0] idx, input tlb_entry_t entry);
        tlb_we     = 1'b1;
        tlb_windex = idx;
        tlb_wentry = entry;
        next_cycle();
        tlb_we = 1'b0;
    endtask

    task automatic sequential_fetch;
        int first;
        checks++;
        // reset pc is one word early, so the first fetch is 0x1C000000
        if (!(inst_req.valid && inst_req.addr == 32'h1C00_0000))
            report_mismatch($sformatf("first request valid %b addr %h",
                                      inst_req.valid, inst_req.addr));
        first = got_q.size();
        wait_items(first + 8);
        check_run(first, 8, 32'h1C00_0000, 32'h1C00_0000, NO_FLAGS, 1'b1);
    endtask

    task automatic backpressure_stretches;
        int          first;
        int          hold;
        logic [31:0] rnd;
        hold = 0;
        refetch_to(32'h1C00_0400, first);
        while (got_q.size() < first + 12)
        begin
            if (hold == 0)
            begin
                rnd        = $random(seed);
                ds_allowin = rnd[0];
                hold       = int'(rnd[3:2]) + 1;    // stretches of 1 to 4 cycles
            end
            hold = hold - 1;
            next_cycle();
        end
        ds_allowin = 1'b1;
        check_run(first, 12, 32'h1C00_0400, 32'h1C00_0400, NO_FLAGS, 1'b1);
    endtask

    task automatic redirect_priority;
        int first;
        csr.refetch_pc = 32'h1C00_1000;
        csr.eentry     = 32'h1C00_2000;
        csr.era        = 32'h1C00_3000;
        branch_to(32'h1C00_0800, first);
        wait_items(first + 4);
        check_run(first, 4, 32'h1C00_0800, 32'h1C00_0800, NO_FLAGS, 1'b1);
        writeback_to(1'b1, 1'b1, 1'b1, first);     // refetch wins
        wait_items(first + 4);
        check_run(first, 4, 32'h1C00_1000, 32'h1C00_1000, NO_FLAGS, 1'b1);
        writeback_to(1'b1, 1'b1, 1'b0, first);     // then exception entry
        wait_items(first + 4);
        check_run(first, 4, 32'h1C00_2000, 32'h1C00_2000, NO_FLAGS, 1'b1);
        writeback_to(1'b0, 1'b1, 1'b0, first);
        wait_items(first + 4);
        check_run(first, 4, 32'h1C00_3000, 32'h1C00_3000, NO_FLAGS, 1'b1);
        br_bus.stall    = 1'b1;
        no_req_expected = 1'b1;
        repeat (5) next_cycle();                    // fetch in flight drains
        first = got_q.size();
        repeat (20) next_cycle();
        checks++;
        if (got_q.size() != first)
            report_mismatch("instruction delivered while a branch stall was held");
        no_req_expected = 1'b0;
        branch_to(32'h1C00_4000, first);
        wait_items(first + 4);
        check_run(first, 4, 32'h1C00_4000, 32'h1C00_4000, NO_FLAGS, 1'b1);
    endtask

    task automatic window_mapping;
        int first;
        csr.crmd            = 32'h0000_0010;        // paging, plv0
        // critical change marks every fetch for refetch
        csr_critical_change = 1'b1;
        refetch_to(32'h8000_1000, first);
        wait_items(first + 4);
        csr_critical_change = 1'b0;
        // vseg 4 maps onto pseg 1
        check_run(first, 4, 32'h8000_1000, 32'h2000_1000, F_REFETCH, 1'b1);
    endtask

    task automatic tlb_faults;
        tlb_entry_t entry;
        int         first;
        csr_asid = 10'd5;
        entry = '{vppn: 19'h20000, asid: 10'd5, g: 1'b0, ppn0: 20'h00123, ppn1: 20'h00456,
                  v0: 1'b1, v1: 1'b1, plv0: 2'd0, plv1: 2'd0};
        write_tlb(2'd0, entry);
        entry = '{vppn: 19'h20001, asid: 10'd0, g: 1'b1, ppn0: 20'h00200, ppn1: 20'h00201,
                  v0: 1'b0, v1: 1'b1, plv0: 2'd0, plv1: 2'd0};
        write_tlb(2'd1, entry);
        entry = '{vppn: 19'h20002, asid: 10'd0, g: 1'b1, ppn0: 20'h00300, ppn1: 20'h00301,
                  v0: 1'b1, v1: 1'b1, plv0: 2'd0, plv1: 2'd0};
        write_tlb(2'd2, entry);
        // crosses from the even to the odd half of the pair
        refetch_to(32'h4000_0FF8, first);
        wait_items(first + 4);
        check_run(first, 2, 32'h4000_0FF8, 32'h0012_3FF8, NO_FLAGS, 1'b1);
        check_run(first + 2, 2, 32'h4000_1000, 32'h0045_6000, NO_FLAGS, 1'b1);
        refetch_to(32'h6000_0000, first);
        wait_items(first + 1);
        check_run(first, 1, 32'h6000_0000, 32'h0, F_TLBR, 1'b0);
        refetch_to(32'h4000_2000, first);
        wait_items(first + 1);
        check_run(first, 1, 32'h4000_2000, 32'h0020_0000, F_PIF, 1'b1);
        csr.crmd = 32'h0000_0013;                   // paging, plv3
        refetch_to(32'h4000_4000, first);
        wait_items(first + 1);
        check_run(first, 1, 32'h4000_4000, 32'h0030_0000, F_PPI, 1'b1);
        csr.crmd = 32'h0000_0008;
        branch_to(32'h1C00_0102, first);
        wait_items(first + 1);
        check_run(first, 1, 32'h1C00_0102, 32'h1C00_0102, F_ADEF, 1'b1);
    endtask

    initial
    begin
        seed                = 32'h0051_dcfd;
        errors              = 0;
        checks              = 0;
        no_req_expected     = 1'b0;
        reset               = 1'b1;
        ds_allowin          = 1'b1;
        br_bus              = '0;
        wb_redirect         = '0;
        csr                 = '0;
        csr.crmd            = 32'h0000_0008;        // direct address mode
        csr.dmw0            = 32'h8200_0009;        // vseg 4 to pseg 1, plv0 and plv3
        csr.dmw1            = 32'h0000_0009;        // identity for the boot region
        csr_critical_change = 1'b0;
        csr_asid            = '0;
        tlb_we              = 1'b0;
        tlb_windex          = '0;
        tlb_wentry          = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        sequential_fetch();
        backpressure_stretches();
        redirect_priority();
        window_mapping();
        tlb_faults();
        $display("checks %0d, errors %0d", checks, errors + mon_errors);
        if (errors + mon_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
